// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int DATA_W         = 8;	// data bus width
	localparam int ADDR_W         = 16;	// address bus width
	localparam int M_CYCLE_CLOCKS = 4;	// clocks per machine cycle

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [1:0]        bus_phase_t;	// clock index inside an m-cycle

	localparam addr_t      RESET_PC   = 16'h0000;	// first opcode fetch
	localparam bus_phase_t LAST_PHASE = bus_phase_t'(M_CYCLE_CLOCKS - 1);	// execute clock

	// upper nibble of F, msb first
	typedef struct packed {
		logic z;	// zero
		logic n;	// subtract
		logic h;	// half carry
		logic c;	// carry
	} flags_t;

	localparam flags_t FLAGS_ALL      = 4'b1111;	// alu ops update all four
	localparam flags_t FLAGS_NO_CARRY = 4'b1110;	// inc/dec keep c

	typedef enum logic [2:0] {
		ifetch,	// opcode fetch
		imm_fetch,	// d8 operand into imml
		imml_fetch,	// a16 low byte
		immh_fetch,	// a16 high byte
		indirect_fetch,	// read from (hl)
		indirect_store,	// write to (hl)
		jump_imm	// idle cycle, pc reload
	} mstate_e;

	// opcode register field order
	typedef enum logic [2:0] {
		reg_b,
		reg_c,
		reg_d,
		reg_e,
		reg_h,
		reg_l,
		reg_m,	// (hl)
		reg_a
	} reg_sel_e;

	// opcode bits 5:3 of the alu group
	typedef enum logic [2:0] {
		alu_add,
		alu_adc,
		alu_sub,
		alu_sbc,
		alu_and,
		alu_xor,
		alu_or,
		alu_cp
	} alu_op_e;

	localparam byte_t OP_HALT  = 8'h76;	// ld (hl),(hl) slot
	localparam byte_t OP_JP    = 8'hc3;
	localparam byte_t OP_JP_NZ = 8'hc2;
	localparam byte_t OP_JP_Z  = 8'hca;
	localparam byte_t OP_JP_NC = 8'hd2;
	localparam byte_t OP_JP_C  = 8'hda;

	// handed to the sequencer at the end of each m-cycle
	typedef struct packed {
		mstate_e next_state;
		logic    load_adr;
		addr_t   adr;	// also the jump target in jump_imm
		logic    load_dout;
		byte_t   dout;
	} bus_req_t;

	typedef struct packed {
		logic     valid;
		reg_sel_e dest;
		byte_t    data;
		logic     flags_valid;
		flags_t   flag_mask;	// bits of F to replace
		flags_t   flags;
	} reg_wr_t;

	typedef struct packed {
		byte_t  result;
		flags_t flags;
	} alu_res_t;

endpackage

`default_nettype wire

// ==== rtl/bus_cycle_sequencer.sv ====
`default_nettype none

module bus_cycle_sequencer import cpu_pkg::*; (
	input  wire           clk,
	input  wire           reset,
	input  wire byte_t    data,
	input  wire bus_req_t req,
	output addr_t         adr,
	output byte_t         dout,
	output logic          ddrv,
	output logic          read,
	output logic          write,
	output logic          cycle_end,
	output mstate_e       state,
	output byte_t         op,
	output byte_t         imml,
	output byte_t         immh,
	output addr_t         pc
);

	bus_phase_t phase;	// clock within m-cycle
	logic       fetch_state;	// bus reads at pc

	assign fetch_state = state inside {ifetch, imm_fetch, imml_fetch, immh_fetch};
	assign cycle_end   = (phase == LAST_PHASE);	// control answers in this clock

	// phase counter, strobes, state and pc
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= '0;
			state <= ifetch;
			pc    <= RESET_PC;
			read  <= 1'b0;
			write <= 1'b0;
			ddrv  <= 1'b0;
		end
		else
		begin
			phase <= cycle_end ? bus_phase_t'(0) : phase + 2'd1;
			case (phase)
			2'd0:
				ddrv <= (state == indirect_store);	// drive data only for stores
			2'd1:
			begin
				read  <= fetch_state || (state == indirect_fetch);
				write <= (state == indirect_store);	// one clock write pulse
				if (fetch_state)
					pc <= pc + 16'd1;	// step past fetched byte
			end
			2'd2:
				write <= 1'b0;
			LAST_PHASE:
			begin
				read  <= 1'b0;
				state <= req.next_state;
				if (state == jump_imm)
					pc <= req.adr;	// taken jp
			end
			endcase
		end
	end

	// bus address, store data and fetched bytes
	always_ff @(posedge clk)
	begin
		case (phase)
		2'd0:
			if (fetch_state)
				adr <= pc;	// indirect states keep loaded adr
		2'd2:
			case (state)
			ifetch:
				op <= data;
			imm_fetch, imml_fetch, indirect_fetch:
				imml <= data;	// d8, a16 low or (hl) byte
			immh_fetch:
				immh <= data;
			default:
				;
			endcase
		LAST_PHASE:
		begin
			if (req.load_adr)
				adr <= req.adr;
			if (req.load_dout)
				dout <= req.dout;
		end
		default:
			;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none

module register_file import cpu_pkg::*; (
	input  wire           clk,
	input  wire           reset,
	input  wire reg_sel_e src,
	input  wire byte_t    mem_byte,
	output byte_t         operand,
	output byte_t         a,
	output addr_t         hl,
	output flags_t        flags,
	input  wire reg_wr_t  wr
);

	byte_t gpr [8];	// indexed by reg_sel_e, slot m stays empty

	// operand select, m takes the fetched memory or immediate byte
	always_comb
	begin
		if (src == reg_m)
			operand = mem_byte;
		else
			operand = gpr[src];
	end

	assign a  = gpr[reg_a];
	assign hl = {gpr[reg_h], gpr[reg_l]};	// indirect address

	// data registers
	always_ff @(posedge clk)
	begin
		if (wr.valid && (wr.dest != reg_m))
			gpr[wr.dest] <= wr.data;
	end

	// F upper nibble, masked update
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (wr.flags_valid)
			flags <= (flags & ~wr.flag_mask) | (wr.flags & wr.flag_mask);
	end

endmodule

`default_nettype wire

// ==== rtl/alu8.sv ====
`default_nettype none

module alu8 import cpu_pkg::*; (
	input  wire byte_t op,
	input  wire byte_t a,
	input  wire byte_t operand,
	input  wire        carry_in,
	output alu_res_t   alu,
	output alu_res_t   incdec
);

	alu_op_e    alu_op;
	logic       cin;	// carry seen by adc/sbc only
	logic [8:0] sum;	// bit 8 is carry or borrow
	logic [8:0] idsum;	// inc/dec result with carry out

	assign alu_op = alu_op_e'(op[5:3]);
	assign cin    = carry_in && ((alu_op == alu_adc) || (alu_op == alu_sbc));

	// eight alu operations on a and operand
	always_comb
	begin
		sum        = 9'd0;
		alu.result = 8'd0;
		alu.flags  = '0;
		case (alu_op)
		alu_add, alu_adc:
		begin
			sum         = {1'b0, a} + {1'b0, operand} + 9'(cin);
			alu.result  = sum[7:0];
			alu.flags.h = a[4] ^ operand[4] ^ sum[4];	// carry into bit 4
			alu.flags.c = sum[8];
		end
		alu_sub, alu_sbc, alu_cp:
		begin
			sum         = {1'b0, a} - {1'b0, operand} - 9'(cin);
			alu.result  = sum[7:0];	// cp drops it later
			alu.flags.n = 1'b1;
			alu.flags.h = a[4] ^ operand[4] ^ sum[4];	// borrow into bit 4
			alu.flags.c = sum[8];	// borrow out
		end
		alu_and:
		begin
			alu.result  = a & operand;
			alu.flags.h = 1'b1;	// and always sets h
		end
		alu_xor:
			alu.result = a ^ operand;
		alu_or:
			alu.result = a | operand;
		endcase
		alu.flags.z = (alu.result == 8'd0);
	end

	// inc/dec, op bit 0 selects dec
	always_comb
	begin
		if (op[0])
			idsum = {1'b0, operand} - 9'd1;
		else
			idsum = {1'b0, operand} + 9'd1;
		incdec.result  = idsum[7:0];
		incdec.flags.z = (idsum[7:0] == 8'd0);
		incdec.flags.n = op[0];
		incdec.flags.h = operand[4] ^ idsum[4];	// nibble wrap
		incdec.flags.c = idsum[8];	// masked off by control
	end

endmodule

`default_nettype wire

// ==== rtl/instruction_control.sv ====
`default_nettype none

module instruction_control import cpu_pkg::*; (
	input  wire mstate_e  state,
	input  wire           cycle_end,
	input  wire byte_t    op,
	input  wire byte_t    imml,
	input  wire byte_t    immh,
	input  wire addr_t    hl,
	input  wire byte_t    a,
	input  wire byte_t    operand,
	input  wire flags_t   flags,
	input  wire alu_res_t alu,
	input  wire alu_res_t incdec,
	output reg_sel_e      src,
	output bus_req_t      req,
	output reg_wr_t       wr
);

	logic    is_incdec;	// 00xxx10x
	logic    from_mem;	// source field is (hl)
	logic    to_mem;	// destination field is (hl)
	logic    taken;	// jp condition holds
	alu_op_e alu_op;

	assign is_incdec = (op[7:6] == 2'b00) && (op[2:1] == 2'b10);
	assign from_mem  = (reg_sel_e'(op[2:0]) == reg_m);
	assign to_mem    = (reg_sel_e'(op[5:3]) == reg_m);
	assign alu_op    = alu_op_e'(op[5:3]);

	// bit 4 picks c or z, bit 3 the wanted level, bit 0 marks plain jp
	assign taken = op[0] || (((op[4]) ? flags.c : flags.z) == op[3]);

	// inc/dec works on the destination field
	assign src = is_incdec ? reg_sel_e'(op[5:3]) : reg_sel_e'(op[2:0]);

	always_comb
	begin
		req.next_state = ifetch;	// most paths end the instruction
		req.load_adr   = 1'b0;
		req.adr        = hl;
		req.load_dout  = 1'b0;
		req.dout       = operand;
		wr.valid       = 1'b0;
		wr.dest        = reg_sel_e'(op[5:3]);
		wr.data        = operand;
		wr.flags_valid = 1'b0;
		wr.flag_mask   = FLAGS_ALL;
		wr.flags       = alu.flags;

		casez (op)
		OP_HALT:
			;	// no halt support
		8'b01??_????:	// ld r,r' / ld r,(hl) / ld (hl),r
			if ((state == ifetch) && from_mem)
			begin
				req.next_state = indirect_fetch;
				req.load_adr   = 1'b1;
			end
			else if (to_mem)
			begin
				if (state == ifetch)
				begin
					req.next_state = indirect_store;
					req.load_adr   = 1'b1;
					req.load_dout  = 1'b1;	// register value to memory
				end
			end
			else
				wr.valid = 1'b1;	// imml in indirect_fetch
		8'b00??_?110:	// ld r,d8 / ld (hl),d8
			if (state == ifetch)
				req.next_state = imm_fetch;
			else if (state == imm_fetch)
			begin
				if (to_mem)
				begin
					req.next_state = indirect_store;
					req.load_adr   = 1'b1;
					req.load_dout  = 1'b1;	// immediate to memory
				end
				else
					wr.valid = 1'b1;
			end
		8'b00??_?10?:	// inc/dec r / (hl)
			if (!to_mem)
			begin
				wr.valid       = 1'b1;
				wr.data        = incdec.result;
				wr.flags_valid = 1'b1;
				wr.flag_mask   = FLAGS_NO_CARRY;
				wr.flags       = incdec.flags;
			end
			else if (state == ifetch)
			begin
				req.next_state = indirect_fetch;
				req.load_adr   = 1'b1;
			end
			else if (state == indirect_fetch)
			begin
				req.next_state = indirect_store;	// write back adjusted byte
				req.load_dout  = 1'b1;
				req.dout       = incdec.result;
				wr.flags_valid = 1'b1;
				wr.flag_mask   = FLAGS_NO_CARRY;
				wr.flags       = incdec.flags;
			end
		8'b10??_????, 8'b11??_?110:	// alu a,r / a,(hl) / a,d8
			if ((state == ifetch) && from_mem)
			begin
				req.next_state = op[6] ? imm_fetch : indirect_fetch;
				req.load_adr   = !op[6];	// hl only for (hl) operand
			end
			else
			begin
				wr.valid       = 1'b1;
				wr.dest        = reg_a;
				wr.data        = (alu_op == alu_cp) ? a : alu.result;	// cp keeps a
				wr.flags_valid = 1'b1;
			end
		OP_JP, OP_JP_NZ, OP_JP_Z, OP_JP_NC, OP_JP_C:
			case (state)
			ifetch:
				req.next_state = imml_fetch;
			imml_fetch:
				req.next_state = immh_fetch;
			immh_fetch:
				req.next_state = taken ? jump_imm : ifetch;	// not taken falls through
			jump_imm:
			begin
				req.load_adr = 1'b1;
				req.adr      = {immh, imml};	// sequencer loads pc from here
			end
			default:
				;
			endcase
		default:
			;	// unsupported opcodes act as nop
		endcase

		// register file commits only at the execute clock
		if (!cycle_end)
		begin
			wr.valid       = 1'b0;
			wr.flags_valid = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`default_nettype none

module cpu_core import cpu_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	output addr_t      adr,
	input  wire byte_t data,
	output byte_t      dout,
	output logic       ddrv,
	output logic       read,
	output logic       write
);

	bus_req_t req;	// control to sequencer
	reg_wr_t  wr;	// control to register file
	mstate_e  state;
	logic     cycle_end;
	byte_t    op;
	byte_t    imml;	// d8, a16 low or (hl) byte
	byte_t    immh;
	reg_sel_e src;
	byte_t    operand;
	byte_t    a;
	addr_t    hl;
	flags_t   flags;
	alu_res_t alu_res;
	alu_res_t incdec_res;

	bus_cycle_sequencer i_sequencer (
		.clk       (clk),
		.reset     (reset),
		.data      (data),
		.req       (req),
		.adr       (adr),
		.dout      (dout),
		.ddrv      (ddrv),
		.read      (read),
		.write     (write),
		.cycle_end (cycle_end),
		.state     (state),
		.op        (op),
		.imml      (imml),
		.immh      (immh),
		.pc        ()	// probe point only
	);

	instruction_control i_control (
		.state     (state),
		.cycle_end (cycle_end),
		.op        (op),
		.imml      (imml),
		.immh      (immh),
		.hl        (hl),
		.a         (a),
		.operand   (operand),
		.flags     (flags),
		.alu       (alu_res),
		.incdec    (incdec_res),
		.src       (src),
		.req       (req),
		.wr        (wr)
	);

	register_file i_regs (
		.clk      (clk),
		.reset    (reset),
		.src      (src),
		.mem_byte (imml),	// code m reads the latched byte
		.operand  (operand),
		.a        (a),
		.hl       (hl),
		.flags    (flags),
		.wr       (wr)
	);

	alu8 i_alu (
		.op       (op),
		.a        (a),
		.operand  (operand),
		.carry_in (flags.c),
		.alu      (alu_res),
		.incdec   (incdec_res)
	);

endmodule

`default_nettype wire

// ==== verification/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam byte_t OPC_NOP     = 8'h00;
localparam byte_t OPC_LD_M_D8 = 8'h36;	// ld (hl),d8

addr_t prog_ptr;	// next program byte

// clears memory and restarts the program at the reset vector
task automatic start_program();
	for (int i = 0; i < 65536; i++)
		mem[i] = OPC_NOP;
	prog_ptr = RESET_PC;
	exp_adr.delete();
	exp_dat.delete();
endtask

task automatic emit(input byte_t b);
	mem[prog_ptr] = b;
	prog_ptr      = prog_ptr + 16'd1;
endtask

task automatic emit_ld_imm(input reg_sel_e r, input byte_t v);
	emit({2'b00, r, 3'b110});
	emit(v);
endtask

task automatic emit_ld(input reg_sel_e d, input reg_sel_e s);
	emit({2'b01, d, s});
endtask

task automatic emit_alu(input alu_op_e o, input reg_sel_e s);
	emit({2'b10, o, s});
endtask

task automatic emit_alu_imm(input alu_op_e o, input byte_t v);
	emit({2'b11, o, 3'b110});
	emit(v);
endtask

task automatic emit_incdec(input reg_sel_e r, input logic dec);
	emit({2'b00, r, 2'b10, dec});
endtask

task automatic emit_jp(input byte_t code, input addr_t target);
	emit(code);
	emit(target[7:0]);	// little endian a16
	emit(target[15:8]);
endtask

`endif

// ==== verification/tb_cpu_core.sv ====
`default_nettype none

module tb_cpu_core import cpu_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	// rough machine-cycle budget of each test
	localparam int TEST_MCYCLES   = 10 + 60 + 25 + 240 + 110 + 150;
	localparam int TIMEOUT_CYCLES = TEST_MCYCLES * M_CYCLE_CLOCKS * 2;

	logic  clk;
	logic  reset;
	addr_t adr;
	byte_t data;
	byte_t dout;
	logic  ddrv;
	logic  read;
	logic  write;

	byte_t mem [65536];	// 64 KiB memory model
	addr_t wr_adr[$];	// observed write pulses
	byte_t wr_dat[$];
	addr_t exp_adr[$];	// expected writes
	byte_t exp_dat[$];
	addr_t rd_adr[$];	// address at each read rise
	int    rd_cyc[$];
	logic  read_q;
	int    cycle_count;
	int    errors;
	int    checks;
	logic  model_c;	// carry as the arithmetic rules leave it
	logic [31:0] lfsr_state;

	`include "tb_programs.svh"

	cpu_core i_dut (
		.clk   (clk),
		.reset (reset),
		.adr   (adr),
		.data  (data),
		.dout  (dout),
		.ddrv  (ddrv),
		.read  (read),
		.write (write)
	);

	always #4 clk = ~clk;	// 8 ns period

	assign data = read ? mem[adr] : 8'h00;	// no wait states

	// bus monitor, write capture and timeout
	always @(posedge clk)
	begin
		cycle_count++;
		if (write)
		begin
			if (!ddrv)
			begin
				errors++;
				$display("write pulse at %0t without data drive", $time);
			end
			mem[adr] = dout;
			wr_adr.push_back(adr);
			wr_dat.push_back(dout);
		end
		if (read && !read_q)
		begin
			rd_adr.push_back(adr);
			rd_cyc.push_back(cycle_count);
		end
		read_q = read;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic byte_t rand_byte();
		byte_t b;
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			b[i] = lfsr_state[0];
		end
		return b;
	endfunction

	// expected a after an alu op and the carry it leaves in model_c
	function automatic byte_t alu_expect(input alu_op_e o, input byte_t x, input byte_t y);
		int r;
		case (o)
		alu_add: r = int'(x) + int'(y);
		alu_adc: r = int'(x) + int'(y) + int'(model_c);
		alu_sub, alu_cp: r = int'(x) - int'(y);
		alu_sbc: r = int'(x) - int'(y) - int'(model_c);
		alu_and: r = int'(x & y);
		alu_xor: r = int'(x ^ y);
		default: r = int'(x | y);
		endcase
		model_c = (r > 255) || (r < 0);	// carry out or borrow
		if (o == alu_cp)
			return x;
		return byte_t'(r & 255);
	endfunction

	task automatic check_addr(input string msg, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_byte(input string msg, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic expect_write(input addr_t a, input byte_t d);
		exp_adr.push_back(a);
		exp_dat.push_back(d);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		wr_adr.delete();
		wr_dat.delete();
		rd_adr.delete();
		rd_cyc.delete();
		model_c = 1'b0;	// F clears on reset
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// resets, waits for every expected write, then compares them
	task automatic run_and_compare(input string name);
		apply_reset();
		while (wr_adr.size() < exp_adr.size())
			@(posedge clk);
		foreach (exp_adr[i])
		begin
			check_addr($sformatf("%s write %0d address", name, i), wr_adr[i], exp_adr[i]);
			check_byte($sformatf("%s write %0d data", name, i), wr_dat[i], exp_dat[i]);
		end
	endtask

	task automatic test_reset_fetch();
		start_program();
		apply_reset();
		check_byte("strobes after reset", {5'd0, read, write, ddrv}, 8'h00);
		while (rd_adr.size() < 4)
			@(posedge clk);
		foreach (rd_adr[i])
			check_addr($sformatf("nop fetch %0d", i), rd_adr[i], addr_t'(i));
		for (int i = 1; i < 4; i++)
			check_byte("fetch spacing", byte_t'(rd_cyc[i] - rd_cyc[i-1]), 8'd4);
	endtask

	task automatic test_load_store();
		reg_sel_e regs [5] = '{reg_b, reg_c, reg_d, reg_e, reg_a};
		byte_t    v;
		start_program();
		emit_ld_imm(reg_h, 8'h80);
		for (int i = 0; i < 5; i++)
		begin
			v = rand_byte();
			emit_ld_imm(regs[i], v);
			expect_write({8'h80, byte_t'(i)}, v);
		end
		for (int i = 0; i < 5; i++)
		begin
			emit_ld_imm(reg_l, byte_t'(i));
			emit_ld(reg_m, regs[i]);
		end
		emit_ld_imm(reg_l, 8'h20);
		emit_ld(reg_m, reg_l);	// l stores itself
		expect_write(16'h8020, 8'h20);
		emit_ld(reg_m, reg_h);
		expect_write(16'h8020, 8'h80);
		v = rand_byte();
		emit_ld_imm(reg_l, 8'h30);
		emit(OPC_LD_M_D8);
		emit(v);
		expect_write(16'h8030, v);
		run_and_compare("load store");
	endtask

	task automatic test_load_indirect();
		byte_t p0;
		byte_t p1;
		start_program();
		p0 = rand_byte();
		p1 = rand_byte();
		mem[16'h9000] = p0;
		mem[16'h9010] = p1;
		emit_ld_imm(reg_h, 8'h90);
		emit_ld_imm(reg_l, 8'h00);
		emit_ld(reg_d, reg_m);
		emit_ld_imm(reg_l, 8'h01);
		emit_ld(reg_m, reg_d);
		emit_ld_imm(reg_l, 8'h10);
		emit_ld(reg_a, reg_m);
		emit_ld_imm(reg_l, 8'h11);
		emit_ld(reg_m, reg_a);
		expect_write(16'h9001, p0);
		expect_write(16'h9011, p1);
		run_and_compare("load indirect");
	endtask

	task automatic test_alu();
		byte_t x;
		byte_t y;
		byte_t l;
		start_program();
		emit_ld_imm(reg_h, 8'ha0);
		for (int o = 0; o < 8; o++)
		begin
			for (int form = 0; form < 3; form++)
			begin
				x = rand_byte();
				y = rand_byte();
				l = byte_t'(o * 4 + form);
				emit_ld_imm(reg_a, x);
				emit_ld_imm(reg_l, l);
				case (form)
				0:
				begin
					emit_ld_imm(reg_b, y);
					emit_alu(alu_op_e'(o), reg_b);
				end
				1:
					emit_alu_imm(alu_op_e'(o), y);
				default:
				begin
					mem[{8'ha0, l}] = y;	// operand in memory
					emit_alu(alu_op_e'(o), reg_m);
				end
				endcase
				emit_ld(reg_m, reg_a);
				expect_write({8'ha0, l}, alu_expect(alu_op_e'(o), x, y));
			end
		end
		run_and_compare("alu");
	endtask

	task automatic test_incdec();
		byte_t vals [4] = '{8'h00, 8'h0f, 8'h10, 8'hff};
		byte_t l;
		start_program();
		emit_ld_imm(reg_h, 8'hb0);
		for (int i = 0; i < 8; i++)
		begin
			l = byte_t'(i * 2);
			emit_ld_imm(reg_c, vals[i/2]);
			emit_incdec(reg_c, i[0]);
			emit_ld_imm(reg_l, l);
			emit_ld(reg_m, reg_c);
			expect_write({8'hb0, l}, i[0] ? vals[i/2] - 8'd1 : vals[i/2] + 8'd1);
			mem[{8'hb0, l + 8'd1}] = vals[i/2];
			emit_ld_imm(reg_l, l + 8'd1);
			emit_incdec(reg_m, i[0]);	// read-modify-write
			expect_write({8'hb0, l + 8'd1}, i[0] ? vals[i/2] - 8'd1 : vals[i/2] + 8'd1);
		end
		run_and_compare("inc dec");
	endtask

	task automatic test_jumps();
		byte_t codes [4] = '{OP_JP_NZ, OP_JP_Z, OP_JP_NC, OP_JP_C};
		byte_t x;
		byte_t y;
		logic  z;
		logic  c;
		logic  hold;
		addr_t target;
		start_program();
		emit_ld_imm(reg_h, 8'hc0);
		for (int i = 0; i < 8; i++)
		begin
			x = 8'h40;
			y = (i % 3 == 0) ? 8'h40 : ((i % 3 == 1) ? 8'h41 : 8'h3f);
			z = (x == y);
			c = (x < y);	// borrow of cp
			case (i / 2)
			0: hold = !z;
			1: hold = z;
			2: hold = !c;
			default: hold = c;
			endcase
			emit_ld_imm(reg_l, byte_t'(i));
			emit_ld_imm(reg_a, x);
			emit_alu_imm(alu_cp, y);
			target = prog_ptr + 16'd8;	// past jp cc, store and jp
			emit_jp(codes[i/2], target);
			emit(OPC_LD_M_D8);
			emit(8'h55);	// fall-through marker
			emit_jp(OP_JP, target + 16'd2);
			emit(OPC_LD_M_D8);
			emit(8'haa);	// target marker
			expect_write({8'hc0, byte_t'(i)}, hold ? 8'haa : 8'h55);
		end
		run_and_compare("jumps");
	endtask

	initial
	begin
		clk         = 1'b0;
		reset       = 1'b1;
		read_q      = 1'b0;
		cycle_count = 0;
		errors      = 0;
		checks      = 0;
		model_c     = 1'b0;
		lfsr_state  = 32'h3f843887;
		test_reset_fetch();
		test_load_store();
		test_load_indirect();
		test_alu();
		test_incdec();
		test_jumps();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verification
rtl/cpu_pkg.sv
rtl/bus_cycle_sequencer.sv
rtl/register_file.sv
rtl/alu8.sv
rtl/instruction_control.sv
rtl/cpu_core.sv
verification/tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/bus_cycle_sequencer.sv
      - rtl/register_file.sv
      - rtl/alu8.sv
      - rtl/instruction_control.sv
      - rtl/cpu_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cpu_core.sv
